// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv) test/tb_ext_bus_funnel.sv test/tb_tasks.svh sources.f

.PHONY: all run clean

all: run

obj_dir/Vtb_ext_bus_funnel: $(SRCS)
	verilator --binary --timing -f sources.f --top-module tb_ext_bus_funnel

run: obj_dir/Vtb_ext_bus_funnel
	@out=$$(./obj_dir/Vtb_ext_bus_funnel); \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== hdl/ext_bus_funnel.sv ====
`timescale 1ns/100ps

module ext_bus_funnel #(
  parameter int unsigned NumPorts     = vip_cfg_pkg::DefNumPorts,
  parameter int unsigned SlvIdWidth   = vip_cfg_pkg::DefSlvIdWidth,
  parameter int unsigned MaxUniqIds   = vip_cfg_pkg::DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = vip_cfg_pkg::DefMaxTxnsPerId
) (
  input  logic                                             periph_clk,
  input  logic                                             rst_n_i,
  // Slave ports
  input  logic               [NumPorts-1:0]                 slv_req_valid_i,
  output logic               [NumPorts-1:0]                 slv_req_ready_o,
  input  vip_bus_pkg::addr_t [NumPorts-1:0]                 slv_req_addr_i,
  input  logic               [NumPorts-1:0][SlvIdWidth-1:0] slv_req_id_i,
  input  logic               [NumPorts-1:0]                 slv_req_write_i,
  input  vip_bus_pkg::data_t [NumPorts-1:0]                 slv_req_wdata_i,
  output logic               [NumPorts-1:0]                 slv_rsp_valid_o,
  input  logic               [NumPorts-1:0]                 slv_rsp_ready_i,
  output logic               [NumPorts-1:0][SlvIdWidth-1:0] slv_rsp_id_o,
  output vip_bus_pkg::data_t [NumPorts-1:0]                 slv_rsp_rdata_o,
  // Master port
  output logic                                             mst_req_valid_o,
  input  logic                                             mst_req_ready_i,
  output vip_bus_pkg::addr_t                               mst_req_addr_o,
  output logic                              [SlvIdWidth-1:0] mst_req_id_o,
  output logic                                             mst_req_write_o,
  output vip_bus_pkg::data_t                               mst_req_wdata_o,
  input  logic                                             mst_rsp_valid_i,
  output logic                                             mst_rsp_ready_o,
  input  logic                              [SlvIdWidth-1:0] mst_rsp_id_i,
  input  vip_bus_pkg::data_t                               mst_rsp_rdata_i
);

  import vip_bus_pkg::*;

  localparam int unsigned WideIdWidth = SlvIdWidth + $clog2(NumPorts);

  // Port prefix has to fit the shared index type
  if (NumPorts > (1 << $bits(port_idx_t))) begin : gen_port_idx_check
    $error("NumPorts does not fit port_idx_t");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wide-ID channel between mux and remapper
  ////////////////////////////////////////////////////////////////////////////

  logic                   wide_req_valid;
  logic                   wide_req_ready;
  addr_t                  wide_req_addr;
  logic [WideIdWidth-1:0] wide_req_id;
  logic                   wide_req_write;
  data_t                  wide_req_wdata;
  logic                   wide_rsp_valid;
  logic                   wide_rsp_ready;
  logic [WideIdWidth-1:0] wide_rsp_id;
  data_t                  wide_rsp_rdata;

  ext_port_mux #(
    .NumPorts   ( NumPorts   ),
    .SlvIdWidth ( SlvIdWidth )
  ) i_port_mux (
    .periph_clk       ( periph_clk      ),
    .rst_n_i          ( rst_n_i         ),
    .slv_req_valid_i  ( slv_req_valid_i ),
    .slv_req_ready_o  ( slv_req_ready_o ),
    .slv_req_addr_i   ( slv_req_addr_i  ),
    .slv_req_id_i     ( slv_req_id_i    ),
    .slv_req_write_i  ( slv_req_write_i ),
    .slv_req_wdata_i  ( slv_req_wdata_i ),
    .slv_rsp_valid_o  ( slv_rsp_valid_o ),
    .slv_rsp_ready_i  ( slv_rsp_ready_i ),
    .slv_rsp_id_o     ( slv_rsp_id_o    ),
    .slv_rsp_rdata_o  ( slv_rsp_rdata_o ),
    .wide_req_valid_o ( wide_req_valid  ),
    .wide_req_ready_i ( wide_req_ready  ),
    .wide_req_addr_o  ( wide_req_addr   ),
    .wide_req_id_o    ( wide_req_id     ),
    .wide_req_write_o ( wide_req_write  ),
    .wide_req_wdata_o ( wide_req_wdata  ),
    .wide_rsp_valid_i ( wide_rsp_valid  ),
    .wide_rsp_ready_o ( wide_rsp_ready  ),
    .wide_rsp_id_i    ( wide_rsp_id     ),
    .wide_rsp_rdata_i ( wide_rsp_rdata  )
  );

  // Narrows the prefixed IDs back to SlvIdWidth
  id_remap_table #(
    .NumPorts     ( NumPorts     ),
    .SlvIdWidth   ( SlvIdWidth   ),
    .MaxUniqIds   ( MaxUniqIds   ),
    .MaxTxnsPerId ( MaxTxnsPerId )
  ) i_id_remap (
    .periph_clk       ( periph_clk      ),
    .rst_n_i          ( rst_n_i         ),
    .wide_req_valid_i ( wide_req_valid  ),
    .wide_req_ready_o ( wide_req_ready  ),
    .wide_req_addr_i  ( wide_req_addr   ),
    .wide_req_id_i    ( wide_req_id     ),
    .wide_req_write_i ( wide_req_write  ),
    .wide_req_wdata_i ( wide_req_wdata  ),
    .wide_rsp_valid_o ( wide_rsp_valid  ),
    .wide_rsp_ready_i ( wide_rsp_ready  ),
    .wide_rsp_id_o    ( wide_rsp_id     ),
    .wide_rsp_rdata_o ( wide_rsp_rdata  ),
    .mst_req_valid_o  ( mst_req_valid_o ),
    .mst_req_ready_i  ( mst_req_ready_i ),
    .mst_req_addr_o   ( mst_req_addr_o  ),
    .mst_req_id_o     ( mst_req_id_o    ),
    .mst_req_write_o  ( mst_req_write_o ),
    .mst_req_wdata_o  ( mst_req_wdata_o ),
    .mst_rsp_valid_i  ( mst_rsp_valid_i ),
    .mst_rsp_ready_o  ( mst_rsp_ready_o ),
    .mst_rsp_id_i     ( mst_rsp_id_i    ),
    .mst_rsp_rdata_i  ( mst_rsp_rdata_i )
  );

endmodule

// ==== hdl/ext_port_mux.sv ====
`timescale 1ns/100ps

module ext_port_mux #(
  parameter int unsigned NumPorts     = vip_cfg_pkg::DefNumPorts,
  parameter int unsigned SlvIdWidth   = vip_cfg_pkg::DefSlvIdWidth,
  localparam int unsigned PortIdxWidth = $clog2(NumPorts),
  localparam int unsigned WideIdWidth  = SlvIdWidth + PortIdxWidth
) (
  input  logic                                       periph_clk,
  input  logic                                       rst_n_i,
  // Slave request channels
  input  logic                 [NumPorts-1:0]                 slv_req_valid_i,
  output logic                 [NumPorts-1:0]                 slv_req_ready_o,
  input  vip_bus_pkg::addr_t   [NumPorts-1:0]                 slv_req_addr_i,
  input  logic                 [NumPorts-1:0][SlvIdWidth-1:0] slv_req_id_i,
  input  logic                 [NumPorts-1:0]                 slv_req_write_i,
  input  vip_bus_pkg::data_t   [NumPorts-1:0]                 slv_req_wdata_i,
  // Slave response channels
  output logic                 [NumPorts-1:0]                 slv_rsp_valid_o,
  input  logic                 [NumPorts-1:0]                 slv_rsp_ready_i,
  output logic                 [NumPorts-1:0][SlvIdWidth-1:0] slv_rsp_id_o,
  output vip_bus_pkg::data_t   [NumPorts-1:0]                 slv_rsp_rdata_o,
  // Wide-ID request towards the remapper
  output logic                                       wide_req_valid_o,
  input  logic                                       wide_req_ready_i,
  output vip_bus_pkg::addr_t                         wide_req_addr_o,
  output logic               [WideIdWidth-1:0]       wide_req_id_o,
  output logic                                       wide_req_write_o,
  output vip_bus_pkg::data_t                         wide_req_wdata_o,
  // Wide-ID response from the remapper
  input  logic                                       wide_rsp_valid_i,
  output logic                                       wide_rsp_ready_o,
  input  logic               [WideIdWidth-1:0]       wide_rsp_id_i,
  input  vip_bus_pkg::data_t                         wide_rsp_rdata_i
);

  logic [PortIdxWidth-1:0] rr_ptr_q;   // First port looked at
  logic [PortIdxWidth-1:0] lock_idx_q;
  logic                    lock_q;     // Granted port still waiting for ready
  logic [PortIdxWidth-1:0] gnt_idx;
  logic [PortIdxWidth-1:0] rsp_port;
  logic                    req_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Request arbitration
  ////////////////////////////////////////////////////////////////////////////

  // Walk backwards so the port closest to the pointer wins
  always_comb begin
    int cand;
    gnt_idx = rr_ptr_q;
    for (int i = NumPorts - 1; i >= 0; i--) begin
      cand = (int'(rr_ptr_q) + i) % int'(NumPorts);
      if (slv_req_valid_i[cand]) begin
        gnt_idx = PortIdxWidth'(cand);
      end
    end
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end
  end

  assign wide_req_valid_o = slv_req_valid_i[gnt_idx];
  assign wide_req_addr_o  = slv_req_addr_i[gnt_idx];
  assign wide_req_id_o    = {gnt_idx, slv_req_id_i[gnt_idx]};  // Port index as prefix
  assign wide_req_write_o = slv_req_write_i[gnt_idx];
  assign wide_req_wdata_o = slv_req_wdata_i[gnt_idx];
  assign req_fire         = wide_req_valid_o & wide_req_ready_i;

  always_comb begin
    slv_req_ready_o          = '0;
    slv_req_ready_o[gnt_idx] = wide_req_ready_i;
  end

  always_ff @(posedge periph_clk) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (req_fire) begin
      lock_q <= 1'b0;
      // Next round starts after the served port
      if (gnt_idx == PortIdxWidth'(NumPorts - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= gnt_idx + 1'b1;
      end
    end else if (wide_req_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////////////////////////////////////////

  assign rsp_port         = wide_rsp_id_i[WideIdWidth-1 -: PortIdxWidth];
  assign wide_rsp_ready_o = slv_rsp_ready_i[rsp_port];

  always_comb begin
    for (int unsigned p = 0; p < NumPorts; p++) begin
      slv_rsp_valid_o[p] = wide_rsp_valid_i && (rsp_port == PortIdxWidth'(p));
      slv_rsp_id_o[p]    = wide_rsp_id_i[SlvIdWidth-1:0];  // Prefix stripped
      slv_rsp_rdata_o[p] = wide_rsp_rdata_i;
    end
  end

endmodule

// ==== hdl/id_remap_table.sv ====
`timescale 1ns/100ps

module id_remap_table #(
  parameter int unsigned NumPorts     = vip_cfg_pkg::DefNumPorts,
  parameter int unsigned SlvIdWidth   = vip_cfg_pkg::DefSlvIdWidth,
  parameter int unsigned MaxUniqIds   = vip_cfg_pkg::DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = vip_cfg_pkg::DefMaxTxnsPerId,
  localparam int unsigned WideIdWidth = SlvIdWidth + $clog2(NumPorts)
) (
  input  logic                         periph_clk,
  input  logic                         rst_n_i,
  // Wide-ID request from the mux
  input  logic                         wide_req_valid_i,
  output logic                         wide_req_ready_o,
  input  vip_bus_pkg::addr_t           wide_req_addr_i,
  input  logic       [WideIdWidth-1:0] wide_req_id_i,
  input  logic                         wide_req_write_i,
  input  vip_bus_pkg::data_t           wide_req_wdata_i,
  // Wide-ID response to the mux
  output logic                         wide_rsp_valid_o,
  input  logic                         wide_rsp_ready_i,
  output logic       [WideIdWidth-1:0] wide_rsp_id_o,
  output vip_bus_pkg::data_t           wide_rsp_rdata_o,
  // Master request
  output logic                         mst_req_valid_o,
  input  logic                         mst_req_ready_i,
  output vip_bus_pkg::addr_t           mst_req_addr_o,
  output logic        [SlvIdWidth-1:0] mst_req_id_o,
  output logic                         mst_req_write_o,
  output vip_bus_pkg::data_t           mst_req_wdata_o,
  // Master response
  input  logic                         mst_rsp_valid_i,
  output logic                         mst_rsp_ready_o,
  input  logic        [SlvIdWidth-1:0] mst_rsp_id_i,
  input  vip_bus_pkg::data_t           mst_rsp_rdata_i
);

  import vip_bus_pkg::*;
  import vip_cfg_pkg::*;

  localparam int unsigned EntryIdxWidth = $clog2(MaxUniqIds);
  localparam int unsigned CntWidth      = $clog2(MaxTxnsPerId + 1);
  localparam logic [CntWidth-1:0] CntMax = CntWidth'(MaxTxnsPerId);

  // Table contents
  remap_entry_state_e       state_q   [MaxUniqIds];
  logic [WideIdWidth-1:0]   wide_id_q [MaxUniqIds];
  logic [CntWidth-1:0]      cnt_q     [MaxUniqIds];
  logic [CntWidth-1:0]      cnt_d     [MaxUniqIds];
  logic [MaxUniqIds-1:0]    entry_inc;
  logic [MaxUniqIds-1:0]    entry_dec;

  // Lookup results
  logic                     hit;
  logic [EntryIdxWidth-1:0] hit_idx;
  logic                     free_found;
  logic [EntryIdxWidth-1:0] free_idx;
  logic [EntryIdxWidth-1:0] sel_idx;
  logic                     entry_ok;
  logic [EntryIdxWidth-1:0] rsp_idx;
  logic                     req_fire;
  logic                     rsp_fire;

  // Output register
  logic                     out_valid_q;
  addr_t                    out_addr_q;
  logic [SlvIdWidth-1:0]    out_id_q;
  logic                     out_write_q;
  data_t                    out_wdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup and allocation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit        = 1'b0;
    hit_idx    = '0;
    free_found = 1'b0;
    free_idx   = '0;
    for (int e = MaxUniqIds - 1; e >= 0; e--) begin
      if (state_q[e] == busy && wide_id_q[e] == wide_req_id_i) begin
        hit     = 1'b1;
        hit_idx = EntryIdxWidth'(e);
      end
      if (state_q[e] == free) begin  // Lowest free one wins
        free_found = 1'b1;
        free_idx   = EntryIdxWidth'(e);
      end
    end
  end

  assign sel_idx  = hit ? hit_idx : free_idx;
  assign entry_ok = hit ? (cnt_q[hit_idx] < CntMax) : free_found;

  // Stall on a full entry, a full table or a blocked output register
  assign wide_req_ready_o = entry_ok && (!out_valid_q || mst_req_ready_i);
  assign req_fire         = wide_req_valid_i && wide_req_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Response translation
  ////////////////////////////////////////////////////////////////////////////

  assign rsp_idx          = mst_rsp_id_i[EntryIdxWidth-1:0];
  assign wide_rsp_valid_o = mst_rsp_valid_i;
  assign wide_rsp_id_o    = wide_id_q[rsp_idx];
  assign wide_rsp_rdata_o = mst_rsp_rdata_i;
  assign mst_rsp_ready_o  = wide_rsp_ready_i;
  assign rsp_fire         = mst_rsp_valid_i && wide_rsp_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Entry bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned e = 0; e < MaxUniqIds; e++) begin
      entry_inc[e] = req_fire && (sel_idx == EntryIdxWidth'(e));
      entry_dec[e] = rsp_fire && (rsp_idx == EntryIdxWidth'(e));
      cnt_d[e]     = cnt_q[e] + CntWidth'(entry_inc[e]) - CntWidth'(entry_dec[e]);
    end
  end

  always_ff @(posedge periph_clk) begin
    if (!rst_n_i) begin
      for (int unsigned e = 0; e < MaxUniqIds; e++) begin
        state_q[e] <= free;
        cnt_q[e]   <= '0;
      end
    end else begin
      for (int unsigned e = 0; e < MaxUniqIds; e++) begin
        cnt_q[e]   <= cnt_d[e];
        state_q[e] <= (cnt_d[e] == '0) ? free : busy;  // Freed on last response
      end
    end
  end

  // Wide ID captured when an entry is taken
  always_ff @(posedge periph_clk) begin
    for (int unsigned e = 0; e < MaxUniqIds; e++) begin
      if (entry_inc[e] && state_q[e] == free) begin
        wide_id_q[e] <= wide_req_id_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Master request register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (req_fire) begin
      out_valid_q <= 1'b1;
    end else if (mst_req_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (req_fire) begin
      out_addr_q  <= wide_req_addr_i;
      out_id_q    <= SlvIdWidth'(sel_idx);  // Narrow ID is the entry number
      out_write_q <= wide_req_write_i;
      out_wdata_q <= wide_req_wdata_i;
    end
  end

  assign mst_req_valid_o = out_valid_q;
  assign mst_req_addr_o  = out_addr_q;
  assign mst_req_id_o    = out_id_q;
  assign mst_req_write_o = out_write_q;
  assign mst_req_wdata_o = out_wdata_q;

endmodule

// ==== hdl/vip_bus_pkg.sv ====
package vip_bus_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Field widths of the reduced external bus
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Wide enough for the default four slave ports
  localparam int unsigned PortIdxWidth = 2;

  //////////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////////

  // Request address
  typedef logic [AddrWidth-1:0] addr_t;

  // Write data on requests, read data on responses
  typedef logic [DataWidth-1:0] data_t;

  // Slave port index, also the prefix of a wide ID
  typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

// ==== hdl/vip_cfg_pkg.sv ====
package vip_cfg_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Default sizing of the bus funnel
  //////////////////////////////////////////////////////////////////////////

  // Slave ports feeding the round-robin mux
  localparam int unsigned DefNumPorts = 4;

  // ID width on every slave port and on the master port
  localparam int unsigned DefSlvIdWidth = 3;

  // Remap entries, one per distinct narrow ID
  localparam int unsigned DefMaxUniqIds = 4;

  // Outstanding transactions allowed per entry
  localparam int unsigned DefMaxTxnsPerId = 2;

  //////////////////////////////////////////////////////////////////////////
  // Remap table entry state
  //////////////////////////////////////////////////////////////////////////

  // An entry is busy while its counter is non-zero
  typedef enum logic {
    free = 1'b0,
    busy = 1'b1
  } remap_entry_state_e;

endpackage

// ==== sources.f ====
+incdir+test
hdl/vip_bus_pkg.sv
hdl/vip_cfg_pkg.sv
hdl/ext_port_mux.sv
hdl/id_remap_table.sv
hdl/ext_bus_funnel.sv
test/tb_ext_bus_funnel.sv

// ==== test/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Reference model of the remap table
bit                     m_busy [MaxUniqIds];
logic [WideIdWidth-1:0] m_wid  [MaxUniqIds];
int                     m_cnt  [MaxUniqIds];

addr_t                 exp_addr_q  [$];
data_t                 exp_wdata_q [$];
logic                  exp_write_q [$];
logic [SlvIdWidth-1:0] exp_nid_q   [$];
int                    order_q     [$];  // Ports in acceptance order
logic [NumPorts-1:0]   fired;
int                    fire_cnt [NumPorts];
int                    pend_cnt [NumPorts];
int                    rsp_cnt;

task automatic fail_now(input string msg);
  $display("ERROR: %s", msg);
  $display("=== FAIL ===");
  $fatal(1);
endtask

task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
  if (act !== exp) begin
    $display("FAIL %s: got %h, expected %h", name, act, exp);
    $display("=== FAIL ===");
    $fatal(1);
  end
endtask

// Hit on a busy entry, else lowest free one; -1 means stall
function automatic int lookup_entry(input logic [WideIdWidth-1:0] wid);
  for (int e = 0; e < MaxUniqIds; e++) begin
    if (m_busy[e] && m_wid[e] == wid) begin
      return (m_cnt[e] < MaxTxnsPerId) ? e : -1;
    end
  end
  for (int e = 0; e < MaxUniqIds; e++) begin
    if (!m_busy[e]) return e;
  end
  return -1;
endfunction

////////////////////////////////////////////////////////////////////////////
// Per-cycle monitor, runs just after the falling edge
////////////////////////////////////////////////////////////////////////////

task automatic sample_cycle();
  int n;
  logic [WideIdWidth-1:0] wid;
  #1;
  fired = req_valid & slv_req_ready_o;
  for (int p = 0; p < NumPorts; p++) begin
    if (fired[p]) begin
      wid = {port_idx_t'(p), req_id[p]};
      n = lookup_entry(wid);
      if (n < 0) fail_now("request accepted while its table entry was unavailable");
      exp_addr_q.push_back(req_addr[p]);
      exp_wdata_q.push_back(req_wdata[p]);
      exp_write_q.push_back(req_write[p]);
      exp_nid_q.push_back(SlvIdWidth'(n));
      m_busy[n] = 1'b1;
      m_wid[n]  = wid;
      m_cnt[n]++;
      fire_cnt[p]++;
      order_q.push_back(p);
    end
  end
  if (mst_rsp_valid && mst_rsp_ready_o) begin
    n = int'(mst_rsp_id);
    if (!m_busy[n]) fail_now("response for a narrow ID with nothing outstanding");
    wid = m_wid[n];
    for (int p = 0; p < NumPorts; p++) begin
      check_val($sformatf("slv_rsp_valid_o[%0d]", p), 64'(slv_rsp_valid_o[p]),
                64'(wid[WideIdWidth-1 -: 2] == port_idx_t'(p)));
    end
    check_val("slv_rsp_id_o", 64'(slv_rsp_id_o[wid[WideIdWidth-1 -: 2]]),
              64'(wid[SlvIdWidth-1:0]));
    check_val("slv_rsp_rdata_o", 64'(slv_rsp_rdata_o[wid[WideIdWidth-1 -: 2]]),
              64'(mst_rsp_rdata));
    m_cnt[n]--;
    if (m_cnt[n] == 0) m_busy[n] = 1'b0;
    rsp_cnt++;
  end
  if (mst_req_valid_o && mst_req_ready) begin
    if (exp_addr_q.size() == 0) fail_now("master request without a matching slave request");
    check_val("mst_req_addr_o", 64'(mst_req_addr_o), 64'(exp_addr_q.pop_front()));
    check_val("mst_req_wdata_o", 64'(mst_req_wdata_o), 64'(exp_wdata_q.pop_front()));
    check_val("mst_req_write_o", 64'(mst_req_write_o), 64'(exp_write_q.pop_front()));
    check_val("mst_req_id_o", 64'(mst_req_id_o), 64'(exp_nid_q.pop_front()));
  end
endtask

// Accepted requests are dropped on the next falling edge
task automatic cycle();
  sample_cycle();
  @(negedge periph_clk);
  for (int p = 0; p < NumPorts; p++) begin
    if (fired[p]) req_valid[p] = 1'b0;
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Drivers
////////////////////////////////////////////////////////////////////////////

task automatic reset_dut();
  req_valid     = '0;
  mst_req_ready = 1'b1;
  mst_rsp_valid = 1'b0;
  rst_n         = 1'b0;
  repeat (8) @(negedge periph_clk);
  rst_n = 1'b1;
  for (int e = 0; e < MaxUniqIds; e++) begin
    m_busy[e] = 1'b0;
    m_cnt[e]  = 0;
  end
  exp_addr_q.delete();
  exp_wdata_q.delete();
  exp_write_q.delete();
  exp_nid_q.delete();
  order_q.delete();
endtask

task automatic raise_req(input int p, input logic [SlvIdWidth-1:0] id, input addr_t addr);
  req_valid[p] = 1'b1;
  req_id[p]    = id;
  req_addr[p]  = addr;
  req_wdata[p] = $urandom();
  req_write[p] = 1'($urandom());
  pend_cnt[p]  = fire_cnt[p];
endtask

task automatic wait_req_fire(input int p);
  for (int t = 0; fire_cnt[p] == pend_cnt[p]; t++) begin
    if (t >= Timeout) fail_now($sformatf("timeout waiting for port %0d to accept", p));
    cycle();
  end
endtask

task automatic send_rsp(input int nid);
  int start;
  start         = rsp_cnt;
  mst_rsp_valid = 1'b1;
  mst_rsp_id    = SlvIdWidth'(nid);
  mst_rsp_rdata = $urandom();
  for (int t = 0; rsp_cnt == start; t++) begin
    if (t >= Timeout) fail_now("timeout waiting for a response transfer");
    cycle();
  end
  mst_rsp_valid = 1'b0;
endtask

task automatic wait_drain();
  for (int t = 0; exp_addr_q.size() > 0; t++) begin
    if (t >= Timeout) fail_now("timeout waiting for master requests to drain");
    cycle();
  end
endtask

task automatic expect_stall(input int p, input int cycles);
  repeat (cycles) begin
    cycle();
    check_val($sformatf("port %0d accept count", p), 64'(fire_cnt[p]), 64'(pend_cnt[p]));
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_single_request();
  reset_dut();
  raise_req(2, 3'd5, $urandom());
  wait_req_fire(2);
  check_val("mst_req_valid_o", 64'(mst_req_valid_o), 64'd1);  // One cycle later
  check_val("mst_req_id_o", 64'(mst_req_id_o), 64'd0);
  wait_drain();
  send_rsp(0);
endtask

task automatic test_round_robin();
  bit again [NumPorts];
  reset_dut();
  for (int p = 0; p < NumPorts; p++) begin
    again[p] = 1'b0;
    raise_req(p, SlvIdWidth'(p), addr_t'(32'h1000 * (p + 1)));
  end
  for (int t = 0; order_q.size() < 2 * NumPorts; t++) begin
    if (t >= Timeout) fail_now("timeout in round-robin sequence");
    cycle();
    for (int p = 0; p < NumPorts; p++) begin
      if (fired[p] && !again[p]) begin
        again[p] = 1'b1;
        raise_req(p, SlvIdWidth'(p), addr_t'(32'h1000 * (p + 1) + 4));
      end
    end
  end
  for (int i = 0; i < 2 * NumPorts; i++) begin
    check_val("granted port", 64'(order_q[i]), 64'(i % NumPorts));
  end
  wait_drain();
  for (int e = 0; e < MaxUniqIds; e++) begin
    send_rsp(e);
    send_rsp(e);
  end
endtask

task automatic test_entry_reuse();
  reset_dut();
  raise_req(1, 3'd3, $urandom());
  wait_req_fire(1);
  raise_req(1, 3'd3, $urandom());
  wait_req_fire(1);
  raise_req(1, 3'd3, $urandom());
  expect_stall(1, 6);  // Entry holds its limit
  wait_drain();
  send_rsp(0);
  wait_req_fire(1);
  wait_drain();
  send_rsp(0);
  send_rsp(0);
endtask

task automatic test_table_full();
  reset_dut();
  for (int p = 0; p < NumPorts; p++) raise_req(p, 3'd1, $urandom());
  for (int p = 0; p < NumPorts; p++) wait_req_fire(p);
  wait_drain();
  raise_req(0, 3'd2, $urandom());
  expect_stall(0, 5);
  send_rsp(2);
  wait_req_fire(0);
  check_val("mst_req_id_o", 64'(mst_req_id_o), 64'd2);
  wait_drain();
  for (int e = 0; e < MaxUniqIds; e++) send_rsp(e);
endtask

task automatic test_back_pressure();
  addr_t held_addr;
  data_t held_wdata;
  logic  held_write;
  reset_dut();
  mst_req_ready = 1'b0;
  raise_req(3, 3'd2, $urandom());
  held_addr  = req_addr[3];
  held_wdata = req_wdata[3];
  held_write = req_write[3];
  wait_req_fire(3);
  raise_req(3, 3'd2, $urandom());
  repeat (5) begin
    cycle();
    check_val("mst_req_valid_o", 64'(mst_req_valid_o), 64'd1);
    check_val("mst_req_addr_o", 64'(mst_req_addr_o), 64'(held_addr));
    check_val("mst_req_wdata_o", 64'(mst_req_wdata_o), 64'(held_wdata));
    check_val("mst_req_write_o", 64'(mst_req_write_o), 64'(held_write));
    check_val("mst_req_id_o", 64'(mst_req_id_o), 64'd0);  // First entry after reset
    check_val("slv_req_ready_o[3]", 64'(slv_req_ready_o[3]), 64'd0);
  end
  mst_req_ready = 1'b1;
  wait_req_fire(3);
  wait_drain();
  send_rsp(0);
  send_rsp(0);
endtask

`endif

// ==== test/tb_ext_bus_funnel.sv ====
`timescale 1ns/100ps

module tb_ext_bus_funnel;

  import vip_bus_pkg::*;
  import vip_cfg_pkg::*;

  localparam int NumPorts     = DefNumPorts;
  localparam int SlvIdWidth   = DefSlvIdWidth;
  localparam int MaxUniqIds   = DefMaxUniqIds;
  localparam int MaxTxnsPerId = DefMaxTxnsPerId;
  localparam int WideIdWidth  = SlvIdWidth + $clog2(NumPorts);
  localparam int Timeout      = 50;  // Cycles per wait

  logic                                 periph_clk;
  logic                                 rst_n;
  logic [NumPorts-1:0]                  req_valid;
  logic [NumPorts-1:0]                  slv_req_ready_o;
  addr_t [NumPorts-1:0]                 req_addr;
  logic [NumPorts-1:0][SlvIdWidth-1:0]  req_id;
  logic [NumPorts-1:0]                  req_write;
  data_t [NumPorts-1:0]                 req_wdata;
  logic [NumPorts-1:0]                  slv_rsp_valid_o;
  logic [NumPorts-1:0][SlvIdWidth-1:0]  slv_rsp_id_o;
  data_t [NumPorts-1:0]                 slv_rsp_rdata_o;
  logic                                 mst_req_valid_o;
  logic                                 mst_req_ready;
  addr_t                                mst_req_addr_o;
  logic [SlvIdWidth-1:0]                mst_req_id_o;
  logic                                 mst_req_write_o;
  data_t                                mst_req_wdata_o;
  logic                                 mst_rsp_valid;
  logic                                 mst_rsp_ready_o;
  logic [SlvIdWidth-1:0]                mst_rsp_id;
  data_t                                mst_rsp_rdata;

  ext_bus_funnel #(
    .NumPorts     ( NumPorts     ),
    .SlvIdWidth   ( SlvIdWidth   ),
    .MaxUniqIds   ( MaxUniqIds   ),
    .MaxTxnsPerId ( MaxTxnsPerId )
  ) UUT (
    .periph_clk      ( periph_clk      ),
    .rst_n_i         ( rst_n           ),
    .slv_req_valid_i ( req_valid       ),
    .slv_req_ready_o ( slv_req_ready_o ),
    .slv_req_addr_i  ( req_addr        ),
    .slv_req_id_i    ( req_id          ),
    .slv_req_write_i ( req_write       ),
    .slv_req_wdata_i ( req_wdata       ),
    .slv_rsp_valid_o ( slv_rsp_valid_o ),
    .slv_rsp_ready_i ( '1              ),  // Slave side always takes responses
    .slv_rsp_id_o    ( slv_rsp_id_o    ),
    .slv_rsp_rdata_o ( slv_rsp_rdata_o ),
    .mst_req_valid_o ( mst_req_valid_o ),
    .mst_req_ready_i ( mst_req_ready   ),
    .mst_req_addr_o  ( mst_req_addr_o  ),
    .mst_req_id_o    ( mst_req_id_o    ),
    .mst_req_write_o ( mst_req_write_o ),
    .mst_req_wdata_o ( mst_req_wdata_o ),
    .mst_rsp_valid_i ( mst_rsp_valid   ),
    .mst_rsp_ready_o ( mst_rsp_ready_o ),
    .mst_rsp_id_i    ( mst_rsp_id      ),
    .mst_rsp_rdata_i ( mst_rsp_rdata   )
  );

  `include "tb_tasks.svh"

  initial begin
    periph_clk = 1'b0;
    forever #2 periph_clk = ~periph_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h839e9def));
    rst_n         = 1'b0;
    req_valid     = '0;
    req_addr      = '0;
    req_id        = '0;
    req_write     = '0;
    req_wdata     = '0;
    mst_req_ready = 1'b1;
    mst_rsp_valid = 1'b0;
    mst_rsp_id    = '0;
    mst_rsp_rdata = '0;

    test_single_request();
    test_round_robin();
    test_entry_reuse();
    test_table_full();
    test_back_pressure();

    $display("=== PASS ===");
    $finish;
  end

endmodule
